/* src/vscale_pkg.sv */
`default_nettype none

package vscale_pkg;

    localparam int PIX_W        = 8;
    localparam int COORD_FRAC_W = 8;  // one input row = 256
    localparam int COORD_W      = 16;
    localparam int COE_W        = 9;
    localparam int LINE_MAX     = 64;
    localparam int ADDR_W       = $clog2(LINE_MAX);
    localparam int SPARSE_GAP   = 2;  // empty cycles per output pixel
    localparam int GAP_W        = $clog2(SPARSE_GAP + 1);
    localparam int NUM_BUF      = 3;
    localparam int MULT_W       = COE_W + PIX_W;
    localparam int APB_ADDR_W   = 4;
    localparam int APB_DATA_W   = 32;

    typedef logic [PIX_W-1:0]      pixel_t;
    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [COORD_W-1:0]    step_t;
    typedef logic [COE_W-1:0]      coe_t;
    typedef logic [ADDR_W-1:0]     col_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [MULT_W:0]       acc_t;

    localparam apb_addr_t REG_CTRL   = 4'h0;
    localparam apb_addr_t REG_STEP   = 4'h4;
    localparam apb_addr_t REG_SIZE   = 4'h8;
    localparam apb_addr_t REG_STATUS = 4'hC;

    localparam step_t  STEP_RESET = 16'd256;
    localparam step_t  STEP_MIN   = 16'd128;  // upscale limit of 2
    localparam col_t   SIZE_RESET = 6'd8;
    localparam coord_t ONE_ROW    = coord_t'(1 << COORD_FRAC_W);
    localparam coe_t   COE_ONE    = coe_t'(1 << COORD_FRAC_W);
    localparam acc_t   ROUND_HALF = acc_t'(1 << (COORD_FRAC_W - 1));

    typedef enum logic [1:0] {
        IDLE,
        PREP,
        LINE_GEN
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/vscale_line_if.sv */
`timescale 1ns/1ps
`default_nettype none

// row pair for one output pixel, qualified by pix_valid
interface vscale_line_if;

    vscale_pkg::pixel_t top_pix;   // row floor(y)
    vscale_pkg::pixel_t bot_pix;   // row floor(y)+1
    vscale_pkg::coe_t   weight;    // fraction of y
    logic               pix_valid;
    logic               line_first;
    logic               frame_first;

    modport ctrl (
        output top_pix, bot_pix, weight, pix_valid, line_first, frame_first
    );

    modport interp (
        input top_pix, bot_pix, weight, pix_valid, line_first, frame_first
    );

endinterface

`default_nettype wire

/* src/vscale_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_regs (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         psel_i,
    input  wire                         penable_i,
    input  wire                         pwrite_i,
    input  wire vscale_pkg::apb_addr_t  paddr_i,
    input  wire vscale_pkg::apb_data_t  pwdata_i,
    input  wire                         line_done_i,
    input  wire                         frame_start_i,
    output vscale_pkg::apb_data_t       prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic                        enable_o,
    output vscale_pkg::step_t           scale_step_o,
    output vscale_pkg::col_t            line_size_o
);

    logic                  acc_err;
    logic                  wr_en;
    vscale_pkg::step_t     step_new;
    vscale_pkg::apb_data_t rd_data;
    vscale_pkg::apb_data_t line_cnt;

    assign pready_o = 1'b1;  // zero wait states

    // STATUS is read only
    assign acc_err = (paddr_i > vscale_pkg::REG_STATUS)
                  || (pwrite_i && paddr_i == vscale_pkg::REG_STATUS);
    assign wr_en   = psel_i && penable_i && pwrite_i && !acc_err;

    assign step_new = (pwdata_i[15:0] < vscale_pkg::STEP_MIN) ? vscale_pkg::STEP_MIN
                                                              : pwdata_i[15:0];

    always_comb begin
        case (paddr_i)
            vscale_pkg::REG_CTRL:   rd_data = vscale_pkg::apb_data_t'(enable_o);
            vscale_pkg::REG_STEP:   rd_data = vscale_pkg::apb_data_t'(scale_step_o);
            vscale_pkg::REG_SIZE:   rd_data = vscale_pkg::apb_data_t'(line_size_o);
            vscale_pkg::REG_STATUS: rd_data = line_cnt;
            default:                rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            enable_o     <= 1'b0;
            scale_step_o <= vscale_pkg::STEP_RESET;
            line_size_o  <= vscale_pkg::SIZE_RESET;
            prdata_o     <= '0;
            pslverr_o    <= 1'b0;
            line_cnt     <= '0;
        end else begin
            // setup phase samples, so both are ready for the access phase
            pslverr_o <= psel_i && !penable_i && acc_err;
            if (psel_i && !penable_i && !pwrite_i) begin
                prdata_o <= rd_data;
            end
            if (wr_en) begin
                case (paddr_i)
                    vscale_pkg::REG_CTRL: enable_o     <= pwdata_i[0];
                    vscale_pkg::REG_STEP: scale_step_o <= step_new;
                    vscale_pkg::REG_SIZE: line_size_o  <= pwdata_i[vscale_pkg::ADDR_W-1:0];
                    default: ;
                endcase
            end
            if (frame_start_i) begin
                line_cnt <= '0;
            end else if (line_done_i) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/vscale_line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_line_store (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire vscale_pkg::pixel_t   pix_i,
    input  wire                       de_i,
    input  wire                       hs_i,
    input  wire                       vs_i,
    input  wire vscale_pkg::col_t     rd_col_i,
    output vscale_pkg::coord_t        rows_done_o,
    output logic [1:0]                wsel_o,
    output logic                      frame_start_o,
    output vscale_pkg::pixel_t        rd_pix_o [vscale_pkg::NUM_BUF]
);

    logic [1:0]       sel_next;
    vscale_pkg::col_t wcol;
    vscale_pkg::col_t wr_col;
    logic             de_q;
    logic             sof;

    assign sof = de_i && hs_i && vs_i;

    // ring position for the pixel on the bus this cycle
    always_comb begin
        sel_next = wsel_o;
        if (de_i && hs_i) begin
            if (vs_i || wsel_o == 2'(vscale_pkg::NUM_BUF - 1)) begin
                sel_next = '0;
            end else begin
                sel_next = wsel_o + 2'd1;
            end
        end
    end

    assign wr_col = hs_i ? '0 : wcol;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wsel_o        <= '0;
            wcol          <= '0;
            de_q          <= 1'b0;
            rows_done_o   <= '0;
            frame_start_o <= 1'b0;
        end else begin
            de_q          <= de_i;
            frame_start_o <= sof;
            if (de_i) begin
                wsel_o <= sel_next;
                wcol   <= wr_col + 1'b1;
            end
            if (sof) begin
                rows_done_o <= '0;
            end else if (de_q && !de_i) begin
                rows_done_o <= rows_done_o + vscale_pkg::ONE_ROW;  // falling de ends a row
            end
        end
    end

    for (genvar b = 0; b < vscale_pkg::NUM_BUF; b++) begin : g_buf
        vscale_pkg::pixel_t mem [vscale_pkg::LINE_MAX];

        always_ff @(posedge clk) begin
            if (de_i && sel_next == 2'(b)) begin
                mem[wr_col] <= pix_i;
            end
            rd_pix_o[b] <= mem[rd_col_i];  // one cycle read latency
        end
    end

endmodule

`default_nettype wire

/* src/vscale_line_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_line_ctrl (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire                       enable_i,
    input  wire vscale_pkg::step_t    scale_step_i,
    input  wire vscale_pkg::col_t     line_size_i,
    input  wire vscale_pkg::coord_t   rows_done_i,
    input  wire [1:0]                 wsel_i,
    input  wire                       frame_start_i,
    input  wire vscale_pkg::pixel_t   rd_pix_i [vscale_pkg::NUM_BUF],
    output vscale_pkg::col_t          rd_col_o,
    output logic                      line_done_o,
    vscale_line_if.ctrl               line_o
);

    vscale_pkg::ctrl_state_t      state;
    vscale_pkg::coord_t           y;
    vscale_pkg::coord_t           need_rows;
    vscale_pkg::coe_t             frac;
    logic [1:0]                   top_sel;
    logic [1:0]                   bot_sel;
    logic [vscale_pkg::GAP_W-1:0] gap_cnt;
    logic                         issue;
    logic                         last_col;
    logic                         valid_q;
    logic                         line_first_q;
    logic                         frame_first_q;

    // rows floor(y) and floor(y)+1 both complete
    assign need_rows = {y[vscale_pkg::COORD_W-1:vscale_pkg::COORD_FRAC_W],
                        {vscale_pkg::COORD_FRAC_W{1'b0}}} + (vscale_pkg::ONE_ROW << 1);

    assign issue    = (state == vscale_pkg::LINE_GEN) && (gap_cnt == '0);
    assign last_col = (rd_col_o == line_size_i - 1'b1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= vscale_pkg::IDLE;
            y           <= '0;
            rd_col_o    <= '0;
            gap_cnt     <= '0;
            top_sel     <= '0;
            bot_sel     <= '0;
            line_done_o <= 1'b0;
        end else begin
            line_done_o <= 1'b0;
            case (state)
                vscale_pkg::IDLE: begin
                    if (enable_i && rows_done_i == need_rows) begin
                        bot_sel <= wsel_i;  // newest complete row
                        top_sel <= (wsel_i == 2'd0) ? 2'(vscale_pkg::NUM_BUF - 1)
                                                    : wsel_i - 2'd1;
                        state   <= vscale_pkg::PREP;
                    end
                end
                vscale_pkg::PREP: begin
                    rd_col_o <= '0;
                    gap_cnt  <= '0;
                    state    <= vscale_pkg::LINE_GEN;
                end
                vscale_pkg::LINE_GEN: begin
                    gap_cnt <= (gap_cnt == vscale_pkg::GAP_W'(vscale_pkg::SPARSE_GAP)) ? '0
                                                                              : gap_cnt + 1'b1;
                    if (issue) begin
                        rd_col_o <= rd_col_o + 1'b1;
                        if (last_col) begin
                            y           <= y + scale_step_i;
                            line_done_o <= 1'b1;
                            state       <= vscale_pkg::IDLE;
                        end
                    end
                end
                default: state <= vscale_pkg::IDLE;
            endcase
            if (frame_start_i) begin
                y     <= '0;
                state <= vscale_pkg::IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == vscale_pkg::PREP) begin
            frac <= vscale_pkg::coe_t'(y[vscale_pkg::COORD_FRAC_W-1:0]);
        end
    end

    // read stage, lines up with the store's registered data
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q       <= 1'b0;
            line_first_q  <= 1'b0;
            frame_first_q <= 1'b0;
        end else begin
            valid_q       <= issue;
            line_first_q  <= issue && rd_col_o == '0;
            frame_first_q <= issue && rd_col_o == '0 && y == '0;
        end
    end

    assign line_o.top_pix     = rd_pix_i[top_sel];
    assign line_o.bot_pix     = rd_pix_i[bot_sel];
    assign line_o.weight      = frac;
    assign line_o.pix_valid   = valid_q;
    assign line_o.line_first  = line_first_q;
    assign line_o.frame_first = frame_first_q;

endmodule

`default_nettype wire

/* src/vscale_interp.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_interp (
    input  wire                 clk,
    input  wire                 rst_i,
    vscale_line_if.interp       line_i,
    output vscale_pkg::pixel_t  pix_o,
    output logic                de_o,
    output logic                hs_o,
    output logic                vs_o
);

    vscale_pkg::pixel_t           top_q;
    vscale_pkg::pixel_t           bot_q;
    vscale_pkg::coe_t             w_top;
    vscale_pkg::coe_t             w_bot;
    logic [vscale_pkg::MULT_W-1:0] prod_top;
    logic [vscale_pkg::MULT_W-1:0] prod_bot;
    vscale_pkg::acc_t             sum;
    logic [1:0]                   de_sr;
    logic [1:0]                   hs_sr;
    logic [1:0]                   vs_sr;

    // weights sum to exactly 1.0, so no clamp is needed
    assign sum = vscale_pkg::acc_t'(prod_top) + vscale_pkg::acc_t'(prod_bot)
               + vscale_pkg::ROUND_HALF;

    always_ff @(posedge clk) begin
        // stage 1: taps and weight table
        top_q <= line_i.top_pix;
        bot_q <= line_i.bot_pix;
        w_top <= vscale_pkg::COE_ONE - line_i.weight;
        w_bot <= line_i.weight;

        // stage 2
        prod_top <= w_top * top_q;
        prod_bot <= w_bot * bot_q;

        pix_o <= sum[vscale_pkg::COORD_FRAC_W +: vscale_pkg::PIX_W];  // drop the fraction
    end

    // strobes follow the data through the same three stages
    always_ff @(posedge clk) begin
        if (rst_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
            de_o  <= 1'b0;
            hs_o  <= 1'b0;
            vs_o  <= 1'b0;
        end else begin
            de_sr[0] <= line_i.pix_valid;
            hs_sr[0] <= line_i.pix_valid && line_i.line_first;
            vs_sr[0] <= line_i.pix_valid && line_i.frame_first;
            de_sr[1] <= de_sr[0];
            hs_sr[1] <= hs_sr[0];
            vs_sr[1] <= vs_sr[0];
            de_o     <= de_sr[1];
            hs_o     <= hs_sr[1];
            vs_o     <= vs_sr[1];
        end
    end

endmodule

`default_nettype wire

/* src/vscale_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_top (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         psel_i,
    input  wire                         penable_i,
    input  wire                         pwrite_i,
    input  wire vscale_pkg::apb_addr_t  paddr_i,
    input  wire vscale_pkg::apb_data_t  pwdata_i,
    output vscale_pkg::apb_data_t       prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    input  wire vscale_pkg::pixel_t     pix_i,
    input  wire                         de_i,
    input  wire                         hs_i,
    input  wire                         vs_i,
    output vscale_pkg::pixel_t          pix_o,
    output logic                        de_o,
    output logic                        hs_o,
    output logic                        vs_o
);

    logic               enable;
    vscale_pkg::step_t  scale_step;
    vscale_pkg::col_t   line_size;
    logic               line_done;
    logic               frame_start;
    vscale_pkg::coord_t rows_done;
    logic [1:0]         wsel;
    vscale_pkg::col_t   rd_col;
    vscale_pkg::pixel_t rd_pix [vscale_pkg::NUM_BUF];

    vscale_line_if line_if ();

    vscale_regs regs0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .line_done_i   (line_done),
        .frame_start_i (frame_start),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .enable_o      (enable),
        .scale_step_o  (scale_step),
        .line_size_o   (line_size)
    );

    vscale_line_store store0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .pix_i         (pix_i),
        .de_i          (de_i),
        .hs_i          (hs_i),
        .vs_i          (vs_i),
        .rd_col_i      (rd_col),
        .rows_done_o   (rows_done),
        .wsel_o        (wsel),
        .frame_start_o (frame_start),
        .rd_pix_o      (rd_pix)
    );

    vscale_line_ctrl ctrl0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .enable_i      (enable),
        .scale_step_i  (scale_step),
        .line_size_i   (line_size),
        .rows_done_i   (rows_done),
        .wsel_i        (wsel),
        .frame_start_i (frame_start),
        .rd_pix_i      (rd_pix),
        .rd_col_o      (rd_col),
        .line_done_o   (line_done),
        .line_o        (line_if.ctrl)
    );

    vscale_interp interp0 (
        .clk    (clk),
        .rst_i  (rst_i),
        .line_i (line_if.interp),
        .pix_o  (pix_o),
        .de_o   (de_o),
        .hs_o   (hs_o),
        .vs_o   (vs_o)
    );

endmodule

`default_nettype wire

/* verification/vscale_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_checker (
    input wire clk,
    input wire rst_i,
    input wire penable_i,
    input wire pslverr_i,
    input wire de_i,
    input wire hs_i,
    input wire vs_i
);

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    a_err_access: assert property (@(posedge clk) disable iff (rst_i) pslverr_i |-> penable_i)
        else begin
            $error("pslverr raised outside the access phase");
            fail_cnt++;
        end

    a_hs_de: assert property (@(posedge clk) disable iff (rst_i) hs_i |-> de_i)
        else begin
            $error("hs_o without de_o");
            fail_cnt++;
        end

    a_vs_hs: assert property (@(posedge clk) disable iff (rst_i) vs_i |-> hs_i)
        else begin
            $error("vs_o without hs_o");
            fail_cnt++;
        end

    // sparse pacing, never two pixels back to back
    a_de_gap: assert property (@(posedge clk) disable iff (rst_i) de_i |=> !de_i)
        else begin
            $error("de_o high in two adjacent cycles");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* verification/vscale_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vscale_tb;

    localparam int MEM_DEPTH = 1024;
    localparam int BLANK_PAD = 16;

    logic                  clk;
    logic                  rst_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    vscale_pkg::apb_addr_t paddr_i;
    vscale_pkg::apb_data_t pwdata_i;
    vscale_pkg::apb_data_t prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    vscale_pkg::pixel_t    pix_i;
    logic                  de_i;
    logic                  hs_i;
    logic                  vs_i;
    vscale_pkg::pixel_t    pix_o;
    logic                  de_o;
    logic                  hs_o;
    logic                  vs_o;

    logic [15:0]           tests [MEM_DEPTH];
    int                    rd_ptr;
    int                    errors;
    int                    checks;
    int                    cycles;
    int                    cycle_limit;
    vscale_pkg::pixel_t    out_pix [$];
    logic                  out_hs [$];
    logic                  out_vs [$];

    vscale_top dut0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .pix_i     (pix_i),
        .de_i      (de_i),
        .hs_i      (hs_i),
        .vs_i      (vs_i),
        .pix_o     (pix_o),
        .de_o      (de_o),
        .hs_o      (hs_o),
        .vs_o      (vs_o)
    );

    bind vscale_top vscale_checker chk0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .penable_i (penable_i),
        .pslverr_i (pslverr_o),
        .de_i      (de_o),
        .hs_i      (hs_o),
        .vs_i      (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // collect output pixels mid-cycle
    always @(negedge clk) begin
        if (!rst_i && de_o) begin
            out_pix.push_back(pix_o);
            out_hs.push_back(hs_o);
            out_vs.push_back(vs_o);
        end
    end

    task automatic check_pix(input vscale_pkg::pixel_t got, input vscale_pkg::pixel_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input vscale_pkg::apb_data_t got,
                             input vscale_pkg::apb_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input bit exp, input string what);
        checks++;
        if (got !== logic'(exp)) begin
            errors++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one zero-wait APB transfer with the response taken in the access phase
    task automatic apb_xfer(input logic wr, input vscale_pkg::apb_addr_t addr,
                            input vscale_pkg::apb_data_t wdata,
                            output vscale_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        check_flag(pready_o, 1'b1, "pready");
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic reg_write(input vscale_pkg::apb_addr_t addr,
                             input vscale_pkg::apb_data_t data, input bit exp_err);
        vscale_pkg::apb_data_t rdata;
        logic                  err;

        apb_xfer(1'b1, addr, data, rdata, err);
        check_flag(err, exp_err, $sformatf("pslverr on write to %0h", addr));
    endtask

    task automatic reg_read(input vscale_pkg::apb_addr_t addr,
                            input vscale_pkg::apb_data_t exp, input bit exp_err);
        vscale_pkg::apb_data_t rdata;
        logic                  err;

        apb_xfer(1'b0, addr, '0, rdata, err);
        check_flag(err, exp_err, $sformatf("pslverr on read of %0h", addr));
        if (!exp_err) begin
            check_reg(rdata, exp, $sformatf("register %0h", addr));
        end
    endtask

    task automatic register_access();
        reg_read(vscale_pkg::REG_CTRL, 32'h0, 1'b0);  // reset values
        reg_read(vscale_pkg::REG_STEP, 32'h100, 1'b0);
        reg_read(vscale_pkg::REG_SIZE, 32'h8, 1'b0);
        reg_write(vscale_pkg::REG_STEP, 32'h180, 1'b0);
        reg_read(vscale_pkg::REG_STEP, 32'h180, 1'b0);
        reg_write(vscale_pkg::REG_STEP, 32'h40, 1'b0);
        reg_read(vscale_pkg::REG_STEP, 32'h80, 1'b0);  // clamped to 2x upscale
        reg_write(vscale_pkg::REG_SIZE, 32'h5, 1'b0);
        reg_read(vscale_pkg::REG_SIZE, 32'h5, 1'b0);
        reg_write(vscale_pkg::REG_CTRL, 32'h1, 1'b0);
        reg_read(vscale_pkg::REG_CTRL, 32'h1, 1'b0);
    endtask

    task automatic bus_errors();
        reg_write(vscale_pkg::REG_STATUS, 32'h102, 1'b1);
        reg_read(vscale_pkg::REG_STATUS, 32'h0, 1'b0);
        reg_write(4'hE, 32'h1C2, 1'b1);
        reg_read(4'hF, 32'h0, 1'b1);
        // nothing may have changed
        reg_read(vscale_pkg::REG_STEP, 32'h80, 1'b0);
        reg_read(vscale_pkg::REG_SIZE, 32'h5, 1'b0);
        reg_read(vscale_pkg::REG_CTRL, 32'h1, 1'b0);
    endtask

    // each row of pixels is followed by 8 x size + 16 blank cycles
    task automatic send_frame(input int size, input int rows);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < size; c++) begin
                @(posedge clk);
                #1;
                pix_i = vscale_pkg::pixel_t'(tests[rd_ptr]);
                de_i  = 1'b1;
                hs_i  = (c == 0);
                vs_i  = (r == 0 && c == 0);
                rd_ptr++;
            end
            @(posedge clk);
            #1;
            pix_i = '0;
            de_i  = 1'b0;
            hs_i  = 1'b0;
            vs_i  = 1'b0;
            repeat (8 * size + BLANK_PAD - 1) @(posedge clk);
        end
    endtask

    task automatic run_test(input int idx);
        int step;
        int size;
        int rows;
        int en;
        int n_out;
        int n_hs;
        string tag;

        step  = tests[rd_ptr];
        size  = tests[rd_ptr + 1];
        rows  = tests[rd_ptr + 2];
        en    = tests[rd_ptr + 3];
        n_out = tests[rd_ptr + 4];
        rd_ptr += 5;
        reg_write(vscale_pkg::REG_STEP, vscale_pkg::apb_data_t'(step), 1'b0);
        reg_write(vscale_pkg::REG_SIZE, vscale_pkg::apb_data_t'(size), 1'b0);
        reg_write(vscale_pkg::REG_CTRL, vscale_pkg::apb_data_t'(en), 1'b0);
        out_pix.delete();
        out_hs.delete();
        out_vs.delete();
        send_frame(size, rows);
        while (out_pix.size() < n_out) begin
            @(posedge clk);
        end
        check_reg(vscale_pkg::apb_data_t'(out_pix.size()), vscale_pkg::apb_data_t'(n_out),
                  $sformatf("test %0d output pixel count", idx));
        n_hs = 0;
        for (int i = 0; i < n_out; i++) begin
            tag = $sformatf("test %0d pixel %0d", idx, i);
            check_pix(out_pix[i], vscale_pkg::pixel_t'(tests[rd_ptr + i]), tag);
            check_flag(out_hs[i], (i % size) == 0, {tag, " hs_o"});
            check_flag(out_vs[i], i == 0, {tag, " vs_o"});
            if (out_hs[i] === 1'b1) begin
                n_hs++;
            end
        end
        rd_ptr += n_out;
        check_reg(vscale_pkg::apb_data_t'(n_hs), vscale_pkg::apb_data_t'(n_out / size),
                  $sformatf("test %0d line count", idx));
        reg_read(vscale_pkg::REG_STATUS, vscale_pkg::apb_data_t'(n_out / size), 1'b0);
    endtask

    initial begin
        int n_tests;
        int p;
        int size;
        int rows;
        int n_out;

        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        pix_i       = '0;
        de_i        = 1'b0;
        hs_i        = 1'b0;
        vs_i        = 1'b0;
        rst_i       = 1'b1;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;

        $readmemh("verification/vscale_tests.txt", tests);
        n_tests = tests[0];
        if (n_tests == 0) begin
            errors++;
            $display("no tests could be read from verification/vscale_tests.txt");
        end
        p = 1;
        for (int t = 0; t < n_tests; t++) begin
            size  = tests[p + 1];
            rows  = tests[p + 2];
            n_out = tests[p + 4];
            cycle_limit += rows * (9 * size + 16) + 200;
            p += 5 + rows * size + n_out;
        end

        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_flag(de_o, 1'b0, "de_o after reset");
        check_flag(hs_o, 1'b0, "hs_o after reset");
        check_flag(vs_o, 1'b0, "vs_o after reset");
        check_flag(pslverr_o, 1'b0, "pslverr after reset");
        check_reg(prdata_o, '0, "prdata after reset");

        register_access();
        bus_errors();
        rd_ptr = 1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.chk0.fail_cnt);
        if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/vscale_pkg.sv
src/vscale_line_if.sv
src/vscale_regs.sv
src/vscale_line_store.sv
src/vscale_line_ctrl.sv
src/vscale_interp.sv
src/vscale_top.sv
verification/vscale_checker.sv
verification/vscale_tb.sv

/* verification/vscale_tests.txt */
// words in hex: test count, then per test a header of step size rows enable n_out,
// then rows x size input pixels, then n_out expected output pixels
4
// unity step, 3 rows of 4
0100 0004 0003 0001 0008
10 20 30 40
11 22 33 44
55 66 77 88
// expected rows 0 and 1
10 20 30 40
11 22 33 44
// downscale 1.5, lines at y = 0, 1.5, 3
0180 0004 0005 0001 000C
00 40 80 FF
10 50 90 F0
20 61 A3 01
30 70 B0 E0
41 81 C1 03
// expected
00 40 80 FF
18 59 9A 79
30 70 B0 E0
// upscale 0.625, lines at y = 0, 0.625, 1.25, 1.875
00A0 0002 0003 0001 0008
00 64
80 C8
FF 10
// expected
00 64
50 A3
A0 9A
EF 27
// enable cleared, no output
0100 0004 0003 0000 0000
5A 5A 5A 5A
A5 A5 A5 A5
3C 3C 3C 3C
